/* source/vita_tx_pkg.sv */
package vita_tx_pkg;

   localparam int SAMPLE_W = 32;

   // FIFO depth is 2**FIFO_AW
   localparam int FIFO_AW = 4;
   localparam logic [FIFO_AW:0] FIFO_DEPTH = {1'b1, {FIFO_AW{1'b0}}};

   // Settings bus register map
   localparam logic [7:0] SR_BASE    = 8'h10;
   localparam logic [7:0] SR_TIME_HI = 8'd0;   // Upper time word, held
   localparam logic [7:0] SR_TIME_LO = 8'd1;   // Lower word, triggers load
   localparam logic [7:0] SR_CLEAR   = 8'd2;   // Data ignored

   typedef struct packed {
      logic                send_at;
      logic                sob;
      logic                eob;
      logic                eop;
      logic [63:0]         send_time;
      logic [SAMPLE_W-1:0] sample;
   } tx_sample_t;

   typedef struct packed {
      logic        stb;
      logic [7:0]  addr;
      logic [31:0] data;
   } set_bus_t;

   typedef enum logic [2:0] {
      ST_IDLE,
      ST_RUN,
      ST_CONT_BURST,
      ST_UNDERRUN,
      ST_UNDERRUN_DONE
   } tx_state_t;

   // Radio time relative to the head send time
   typedef enum logic [1:0] {TIME_EARLY, TIME_NOW, TIME_LATE} time_rel_t;

endpackage

/* source/tx_settings_regs.sv */
module tx_settings_regs
   import vita_tx_pkg::*;
(
   input  logic        clk,
   input  logic        rst_i,
   input  set_bus_t    set_i,
   output logic        time_load_o,
   output logic [63:0] time_value_o,
   output logic        clear_state_o
);

   logic        hit_time_hi;
   logic        hit_time_lo;
   logic        hit_clear;
   logic [31:0] time_hi;

   assign hit_time_hi = set_i.stb && (set_i.addr == SR_BASE + SR_TIME_HI);
   assign hit_time_lo = set_i.stb && (set_i.addr == SR_BASE + SR_TIME_LO);
   assign hit_clear   = set_i.stb && (set_i.addr == SR_BASE + SR_CLEAR);

   // Upper word waits here for the low word
   always_ff @(posedge clk) begin
      if (hit_time_hi) begin
         time_hi <= set_i.data;
      end
   end

   always_ff @(posedge clk) begin
      if (hit_time_lo) begin
         time_value_o <= {time_hi, set_i.data};
      end
   end

   // Single-cycle pulses, one cycle after the write
   always_ff @(posedge clk) begin
      if (rst_i) begin
         time_load_o   <= 1'b0;
         clear_state_o <= 1'b0;
      end else begin
         time_load_o   <= hit_time_lo;
         clear_state_o <= hit_clear;
      end
   end

endmodule

/* source/vita_time_counter.sv */
module vita_time_counter (
   input  logic        clk,
   input  logic        rst_i,
   input  logic        load_i,
   input  logic [63:0] load_value_i,
   output logic [63:0] time_o
);

   // Free-running radio time
   always_ff @(posedge clk) begin
      if (rst_i) begin
         time_o <= 64'd0;
      end else if (load_i) begin
         time_o <= load_value_i;   // Visible the cycle after the request
      end else begin
         time_o <= time_o + 64'd1;
      end
   end

endmodule

/* source/tx_sample_fifo.sv */
module tx_sample_fifo
   import vita_tx_pkg::*;
(
   input  logic       clk,
   input  logic       rst_i,
   input  logic       clear_i,
   input  tx_sample_t wr_data_i,
   input  logic       wr_src_rdy_i,
   output logic       wr_dst_rdy_o,
   output tx_sample_t rd_data_o,
   output logic       rd_src_rdy_o,
   input  logic       rd_dst_rdy_i
);

   tx_sample_t         mem [FIFO_DEPTH];
   logic [FIFO_AW-1:0] wr_ptr;
   logic [FIFO_AW-1:0] rd_ptr;
   logic [FIFO_AW:0]   count;
   logic [FIFO_AW:0]   count_next;
   logic               not_full_q;
   logic               push;
   logic               pop;

   assign rd_src_rdy_o = (count != '0);
   assign rd_data_o    = mem[rd_ptr];      // Head shown with no read latency

   assign pop  = rd_src_rdy_o & rd_dst_rdy_i;
   // A pop in this cycle makes room even when full
   assign wr_dst_rdy_o = not_full_q | pop;
   assign push = wr_src_rdy_i & wr_dst_rdy_o;

   always_comb begin
      count_next = count;
      if (push && !pop) begin
         count_next = count + 1'b1;
      end else if (pop && !push) begin
         count_next = count - 1'b1;
      end
   end

   always_ff @(posedge clk) begin
      if (push) begin
         mem[wr_ptr] <= wr_data_i;
      end
   end

   always_ff @(posedge clk) begin
      if (rst_i || clear_i) begin
         wr_ptr     <= '0;
         rd_ptr     <= '0;
         count      <= '0;
         not_full_q <= 1'b0;   // Ready rises one cycle out of reset
      end else begin
         if (push) begin
            wr_ptr <= wr_ptr + 1'b1;
         end
         if (pop) begin
            rd_ptr <= rd_ptr + 1'b1;
         end
         count      <= count_next;
         not_full_q <= (count_next != FIFO_DEPTH);
      end
   end

endmodule

/* source/vita_tx_control.sv */
module vita_tx_control
   import vita_tx_pkg::*;
(
   input  logic                clk,
   input  logic                rst_i,
   input  logic                clear_state_i,
   input  logic [63:0]         vita_time_i,
   input  tx_sample_t          head_i,
   input  logic                head_src_rdy_i,
   output logic                head_dst_rdy_o,
   input  logic                strobe_i,
   output logic [SAMPLE_W-1:0] sample_o,
   output logic                run_o,
   output logic                underrun_o
);

   tx_state_t state;
   time_rel_t time_rel;

   // No too-early window, anything before send_time just waits
   always_comb begin
      if (vita_time_i == head_i.send_time) begin
         time_rel = TIME_NOW;
      end else if (vita_time_i > head_i.send_time) begin
         time_rel = TIME_LATE;
      end else begin
         time_rel = TIME_EARLY;
      end
   end

   always_ff @(posedge clk) begin
      if (rst_i || clear_state_i) begin
         state <= ST_IDLE;
      end else begin
         case (state)
            ST_IDLE: begin
               if (head_src_rdy_i) begin
                  if (!head_i.send_at || time_rel == TIME_NOW) begin
                     state <= ST_RUN;
                  end else if (time_rel == TIME_LATE) begin
                     state <= ST_UNDERRUN;
                  end
               end
            end

            ST_RUN: begin
               if (strobe_i) begin
                  if (!head_src_rdy_i) begin
                     state <= ST_UNDERRUN;   // FIFO ran dry mid-packet
                  end else if (head_i.eop) begin
                     state <= head_i.eob ? ST_IDLE : ST_CONT_BURST;
                  end
               end
            end

            // Burst continues, next packet must beat the next strobe
            ST_CONT_BURST: begin
               if (strobe_i) begin
                  state <= ST_UNDERRUN_DONE;
               end else if (head_src_rdy_i) begin
                  state <= ST_RUN;
               end
            end

            ST_UNDERRUN: begin
               if (head_src_rdy_i && head_i.eop) begin
                  state <= ST_UNDERRUN_DONE;
               end
            end

            ST_UNDERRUN_DONE: begin
               state <= ST_UNDERRUN_DONE;   // Sticky until software clear
            end

            default: begin
               state <= ST_IDLE;
            end
         endcase
      end
   end

   // Drain the rest of a bad packet, or pop one word per strobe
   assign head_dst_rdy_o = (state == ST_UNDERRUN) || (strobe_i && state == ST_RUN);
   assign run_o          = (state == ST_RUN) || (state == ST_CONT_BURST);
   assign underrun_o     = (state == ST_UNDERRUN_DONE);
   assign sample_o       = head_i.sample;

endmodule

/* source/vita_tx_top.sv */
module vita_tx_top
   import vita_tx_pkg::*;
(
   input  logic                clk,
   input  logic                rst_i,
   input  set_bus_t            set_i,
   input  tx_sample_t          in_i,
   input  logic                in_src_rdy_i,
   output logic                in_dst_rdy_o,
   input  logic                strobe_i,
   output logic [SAMPLE_W-1:0] sample_o,
   output logic                run_o,
   output logic                underrun_o,
   output logic [63:0]         vita_time_o
);

   logic        time_load;
   logic [63:0] time_value;
   logic        clear_state;
   tx_sample_t  head;
   logic        head_src_rdy;
   logic        head_dst_rdy;

   tx_settings_regs u_settings (
      .clk           (clk),
      .rst_i         (rst_i),
      .set_i         (set_i),
      .time_load_o   (time_load),
      .time_value_o  (time_value),
      .clear_state_o (clear_state)
   );

   vita_time_counter u_time (
      .clk          (clk),
      .rst_i        (rst_i),
      .load_i       (time_load),
      .load_value_i (time_value),
      .time_o       (vita_time_o)
   );

   // Contents survive a control clear
   tx_sample_fifo u_fifo (
      .clk          (clk),
      .rst_i        (rst_i),
      .clear_i      (rst_i),
      .wr_data_i    (in_i),
      .wr_src_rdy_i (in_src_rdy_i),
      .wr_dst_rdy_o (in_dst_rdy_o),
      .rd_data_o    (head),
      .rd_src_rdy_o (head_src_rdy),
      .rd_dst_rdy_i (head_dst_rdy)
   );

   vita_tx_control u_control (
      .clk            (clk),
      .rst_i          (rst_i),
      .clear_state_i  (clear_state),
      .vita_time_i    (vita_time_o),
      .head_i         (head),
      .head_src_rdy_i (head_src_rdy),
      .head_dst_rdy_o (head_dst_rdy),
      .strobe_i       (strobe_i),
      .sample_o       (sample_o),
      .run_o          (run_o),
      .underrun_o     (underrun_o)
   );

endmodule

/* sim/tb_clock_gen.sv */
module tb_clock_gen (
   output logic clk_o
);

   initial begin
      clk_o = 1'b0;
      forever begin
         #10 clk_o = ~clk_o;   // Period 20
      end
   end

endmodule

/* sim/vita_tx_checker.sv */
module vita_tx_checker
   import vita_tx_pkg::*;
(
   input logic      clk,
   input logic      rst_i,
   input logic      run_i,
   input logic      underrun_i,
   input logic      clear_state_i,
   input tx_state_t state_i
);

   int n_fail = 0;   // Failed assertions so far

   run_xor_underrun: assert property (@(posedge clk) disable iff (rst_i)
      !(run_i && underrun_i))
      else begin
         $error("run_o and underrun_o are high in the same cycle");
         n_fail++;
      end

   quiet_after_reset: assert property (@(posedge clk)
      rst_i |=> (!run_i && !underrun_i))
      else begin
         $error("run_o or underrun_o high in the cycle after reset");
         n_fail++;
      end

   // Underrun is sticky until software clears it
   underrun_sticky: assert property (@(posedge clk) disable iff (rst_i)
      (state_i == ST_UNDERRUN_DONE && !clear_state_i) |=> (state_i == ST_UNDERRUN_DONE))
      else begin
         $error("control left ST_UNDERRUN_DONE without a clear");
         n_fail++;
      end

endmodule

bind vita_tx_top vita_tx_checker u_checker (
   .clk           (clk),
   .rst_i         (rst_i),
   .run_i         (run_o),
   .underrun_i    (underrun_o),
   .clear_state_i (clear_state),
   .state_i       (u_control.state)
);

/* sim/vita_tx_tb.sv */
module vita_tx_tb
   import vita_tx_pkg::*;
();

   typedef enum {WAIT_RUN, WAIT_STOPPED, WAIT_DRAINED, WAIT_UNDERRUN, WAIT_CLEARED} wait_t;

   logic                clk;
   logic                rst_i;
   set_bus_t            set_i;
   tx_sample_t          in_i;
   logic                in_src_rdy_i;
   logic                in_dst_rdy_o;
   logic                strobe_i;
   logic [SAMPLE_W-1:0] sample_o;
   logic                run_o;
   logic                underrun_o;
   logic [63:0]         vita_time_o;

   int                  strobe_mode = 0;   // 0 off, 1 random, 2 alternating
   string               test_name = "reset";
   int                  test_num = 0;
   int                  test_err = 0;
   int                  n_err = 0;
   int                  n_checks = 0;
   tx_sample_t          pkt [$];
   logic [SAMPLE_W-1:0] got [$];   // Samples seen leaving on a strobe

   // Reference model state as seen after the latest rising edge
   tx_state_t   m_state = ST_IDLE;
   tx_sample_t  m_fifo [$];
   logic [63:0] m_time = '0;
   logic [31:0] m_time_hi = '0;
   logic [63:0] m_load_val = '0;
   logic        m_load_q = 1'b0;
   logic        m_clear_q = 1'b0;
   logic        m_not_full = 1'b0;

   tb_clock_gen u_clk (.clk_o(clk));

   vita_tx_top uut (
      .clk          (clk),
      .rst_i        (rst_i),
      .set_i        (set_i),
      .in_i         (in_i),
      .in_src_rdy_i (in_src_rdy_i),
      .in_dst_rdy_o (in_dst_rdy_o),
      .strobe_i     (strobe_i),
      .sample_o     (sample_o),
      .run_o        (run_o),
      .underrun_o   (underrun_o),
      .vita_time_o  (vita_time_o)
   );

   task automatic count_error();
      test_err++;
      n_err++;
   endtask

   task automatic check_sample(input string what, input logic [SAMPLE_W-1:0] exp,
                               input logic [SAMPLE_W-1:0] act);
      n_checks++;
      if (act !== exp) begin
         $display("MISMATCH %s %s: expected %h, actual %h", test_name, what, exp, act);
         count_error();
      end
   endtask

   task automatic check_flag(input string what, input logic exp, input logic act);
      n_checks++;
      if (act !== exp) begin
         $display("MISMATCH %s %s: expected %b, actual %b", test_name, what, exp, act);
         count_error();
      end
   endtask

   task automatic check_time(input string what, input logic [63:0] exp,
                             input logic [63:0] act);
      n_checks++;
      if (act !== exp) begin
         $display("MISMATCH %s %s: expected %h, actual %h", test_name, what, exp, act);
         count_error();
      end
   endtask

   // Outputs are compared at the falling edge, then the model steps
   always @(negedge clk) begin : model
      tx_sample_t head;
      tx_state_t  next;
      time_rel_t  rel;
      logic       fifo_ne;
      logic       pop;
      logic       push;
      logic       exp_rdy;
      fifo_ne = (m_fifo.size() != 0);
      head = fifo_ne ? m_fifo[0] : '0;
      if (m_time == head.send_time) begin
         rel = TIME_NOW;
      end else if (m_time > head.send_time) begin
         rel = TIME_LATE;
      end else begin
         rel = TIME_EARLY;
      end
      pop = fifo_ne && ((m_state == ST_UNDERRUN) || (strobe_i && m_state == ST_RUN));
      exp_rdy = m_not_full || pop;   // A pop makes room in the same cycle
      push = in_src_rdy_i && exp_rdy;
      check_flag("run_o", (m_state == ST_RUN) || (m_state == ST_CONT_BURST), run_o);
      check_flag("underrun_o", m_state == ST_UNDERRUN_DONE, underrun_o);
      check_flag("in_dst_rdy_o", exp_rdy, in_dst_rdy_o);
      check_time("vita_time_o", m_time, vita_time_o);
      if (m_state == ST_RUN && fifo_ne) begin
         check_sample("sample_o", head.sample, sample_o);
      end
      if (!rst_i && run_o && strobe_i) begin
         got.push_back(sample_o);
      end
      if (rst_i) begin
         m_state = ST_IDLE;
         m_fifo.delete();
         m_time = '0;
         m_load_q = 1'b0;
         m_clear_q = 1'b0;
         m_not_full = 1'b0;
      end else begin
         next = m_state;
         case (m_state)
            ST_IDLE: begin
               if (fifo_ne && (!head.send_at || rel == TIME_NOW)) begin
                  next = ST_RUN;
               end else if (fifo_ne && rel == TIME_LATE) begin
                  next = ST_UNDERRUN;
               end
            end
            ST_RUN: begin
               if (strobe_i && !fifo_ne) begin
                  next = ST_UNDERRUN;
               end else if (strobe_i && head.eop) begin
                  next = head.eob ? ST_IDLE : ST_CONT_BURST;
               end
            end
            ST_CONT_BURST: begin
               if (strobe_i) begin
                  next = ST_UNDERRUN_DONE;
               end else if (fifo_ne) begin
                  next = ST_RUN;
               end
            end
            ST_UNDERRUN: begin
               if (fifo_ne && head.eop) begin
                  next = ST_UNDERRUN_DONE;
               end
            end
            default: ;
         endcase
         if (m_clear_q) begin
            next = ST_IDLE;
         end
         if (pop) begin
            head = m_fifo.pop_front();
         end
         if (push) begin
            m_fifo.push_back(in_i);
         end
         m_not_full = (m_fifo.size() != 2 ** FIFO_AW);
         m_time = m_load_q ? m_load_val : m_time + 64'd1;
         m_load_q = set_i.stb && (set_i.addr == SR_BASE + SR_TIME_LO);
         if (m_load_q) begin
            m_load_val = {m_time_hi, set_i.data};
         end
         if (set_i.stb && (set_i.addr == SR_BASE + SR_TIME_HI)) begin
            m_time_hi = set_i.data;
         end
         m_clear_q = set_i.stb && (set_i.addr == SR_BASE + SR_CLEAR);
         m_state = next;
      end
   end

   // DSP strobe source
   always @(posedge clk) begin
      #2;
      if (strobe_mode == 1) begin
         strobe_i = $urandom % 2;
      end else if (strobe_mode == 2) begin
         strobe_i = !strobe_i;
      end else begin
         strobe_i = 1'b0;
      end
   end

   task automatic write_set(input logic [7:0] offset, input logic [31:0] data);
      set_i.stb  = 1'b1;
      set_i.addr = SR_BASE + offset;
      set_i.data = data;
      @(posedge clk);
      #2;
      set_i = '0;
   endtask

   task automatic load_time(output logic [63:0] value);
      value = {$urandom, $urandom} | 64'h1000;
      write_set(SR_TIME_HI, value[63:32]);
      write_set(SR_TIME_LO, value[31:0]);
   endtask

   task automatic build_packet(input int len, input logic timed, input logic [63:0] t,
                               input logic eob);
      tx_sample_t w;
      for (int i = 0; i < len; i++) begin
         w = '0;
         w.send_at = timed && (i == 0);
         w.sob = (i == 0);
         w.eop = (i == len - 1);
         w.eob = eob && (i == len - 1);
         w.send_time = t;
         w.sample = $urandom;
         pkt.push_back(w);
      end
   endtask

   task automatic offer_word(input tx_sample_t w, input int max_cycles, output logic taken);
      int n;
      n = 0;
      taken = 1'b0;
      in_i = w;
      in_src_rdy_i = 1'b1;
      while (!taken && n < max_cycles) begin
         @(negedge clk);
         taken = in_dst_rdy_o;
         @(posedge clk);
         #2;
         n++;
      end
      in_src_rdy_i = 1'b0;
   endtask

   task automatic push_words(input int first, input int last);
      logic taken;
      for (int i = first; i <= last; i++) begin
         offer_word(pkt[i], 500, taken);
         if (!taken) begin
            $display("%s: FIFO did not accept word %0d", test_name, i);
            count_error();
         end
      end
   endtask

   task automatic wait_for(input wait_t cond, input string desc);
      int   n;
      logic done;
      n = 0;
      done = 1'b0;
      while (!done) begin
         case (cond)
            WAIT_RUN:      done = run_o;
            WAIT_STOPPED:  done = !run_o;
            WAIT_DRAINED:  done = !run_o && (m_fifo.size() == 0);
            WAIT_UNDERRUN: done = underrun_o;
            default:       done = !underrun_o;
         endcase
         if (!done && n == 500) begin
            $display("%s: timed out waiting for %s", test_name, desc);
            count_error();
            done = 1'b1;
         end else if (!done) begin
            @(posedge clk);
            #2;
            n++;
         end
      end
   endtask

   task automatic clear_control();
      write_set(SR_CLEAR, $urandom);
      wait_for(WAIT_CLEARED, "underrun_o to clear");
   endtask

   task automatic begin_test(input string name);
      test_name = name;
      test_num++;
      test_err = 0;
   endtask

   task automatic end_test();
      if (test_err == 0) begin
         $display("test %0d %s: ok", test_num, test_name);
      end else begin
         $display("test %0d %s: %0d errors", test_num, test_name, test_err);
      end
   endtask

   initial begin
      int          len;
      int          cut;
      int          c0;
      logic        taken;
      logic [63:0] t0;
      logic [63:0] send_time;
      c0 = $urandom(20);   // Seed once
      rst_i = 1'b1;
      set_i = '0;
      in_i = '0;
      in_src_rdy_i = 1'b0;
      strobe_i = 1'b0;
      repeat (4) @(posedge clk);
      #2;
      rst_i = 1'b0;

      begin_test("untimed burst");
      pkt.delete();
      build_packet(1 + $urandom % 6, 1'b0, '0, 1'b1);
      build_packet(1 + $urandom % 6, 1'b0, '0, 1'b1);
      push_words(0, pkt.size() - 1);
      strobe_mode = 1;
      wait_for(WAIT_DRAINED, "burst to finish");
      strobe_mode = 0;
      check_flag("underrun_o at end", 1'b0, underrun_o);
      end_test();

      begin_test("timed start");
      load_time(t0);
      send_time = t0 + 10 + $urandom % 51;
      pkt.delete();
      build_packet(1 + $urandom % 6, 1'b1, send_time, 1'b1);
      push_words(0, pkt.size() - 1);
      strobe_mode = 1;
      wait_for(WAIT_RUN, "timed burst to start");
      check_time("time at first run_o", send_time + 64'd1, vita_time_o);
      wait_for(WAIT_DRAINED, "timed burst to finish");
      strobe_mode = 0;
      end_test();

      begin_test("late packet");
      load_time(t0);
      pkt.delete();
      build_packet(1 + $urandom % 6, 1'b1, t0 - 1 - $urandom % 50, 1'b1);
      push_words(0, pkt.size() - 1);
      strobe_mode = 1;
      wait_for(WAIT_UNDERRUN, "underrun on late packet");
      strobe_mode = 0;
      check_flag("run_o after late packet", 1'b0, run_o);
      clear_control();
      end_test();

      begin_test("starvation");
      pkt.delete();
      len = 2 + $urandom % 5;
      cut = 1 + $urandom % (len - 1);
      build_packet(len, 1'b0, '0, 1'b1);
      push_words(0, cut - 1);
      wait_for(WAIT_RUN, "packet to start");
      strobe_mode = 1;
      wait_for(WAIT_STOPPED, "FIFO to run dry");
      strobe_mode = 0;
      push_words(cut, len - 1);   // Rest of the packet is discarded
      wait_for(WAIT_UNDERRUN, "underrun after starvation");
      clear_control();
      end_test();

      begin_test("continued burst");
      pkt.delete();
      build_packet(1 + $urandom % 6, 1'b0, '0, 1'b0);
      build_packet(1 + $urandom % 6, 1'b0, '0, 1'b1);
      push_words(0, pkt.size() - 1);
      strobe_mode = 2;
      wait_for(WAIT_DRAINED, "continued burst to finish");
      strobe_mode = 0;
      check_flag("underrun_o after burst", 1'b0, underrun_o);
      pkt.delete();
      build_packet(1 + $urandom % 6, 1'b0, '0, 1'b0);
      push_words(0, pkt.size() - 1);
      strobe_mode = 2;
      wait_for(WAIT_UNDERRUN, "underrun in open burst");
      strobe_mode = 0;
      end_test();

      begin_test("clear and back-pressure");
      strobe_mode = 0;
      clear_control();
      pkt.delete();
      for (int i = 0; i < 4; i++) begin
         build_packet(5, 1'b0, '0, 1'b1);
      end
      c0 = got.size();
      push_words(0, 15);
      offer_word(pkt[16], 8, taken);
      check_flag("word taken while full", 1'b0, taken);
      check_flag("in_dst_rdy_o when full", 1'b0, in_dst_rdy_o);
      strobe_mode = 1;
      push_words(16, 19);
      wait_for(WAIT_DRAINED, "FIFO to drain");
      strobe_mode = 0;
      for (int i = 0; i < 20; i++) begin
         if (c0 + i < got.size()) begin
            check_sample("consumed word", pkt[i].sample, got[c0 + i]);
         end else begin
            $display("%s: word %0d never reached the DSP side", test_name, i);
            count_error();
         end
      end
      end_test();

      n_err += uut.u_checker.n_fail;
      $display("tests %0d, checks %0d, errors %0d", test_num, n_checks, n_err);
      if (n_err == 0) begin
         $display("Done: no errors");
      end else begin
         $display("Done: errors found");
      end
      $finish;
   end

   // 2000 clock periods for each of the six tests
   initial begin
      #(20 * 2000 * 6);
      $display("watchdog stopped the run after %0d cycles", 2000 * 6);
      $display("Done: errors found");
      $finish;
   end

endmodule

/* src.f */
source/vita_tx_pkg.sv
source/tx_settings_regs.sv
source/vita_time_counter.sv
source/tx_sample_fifo.sv
source/vita_tx_control.sv
source/vita_tx_top.sv
sim/tb_clock_gen.sv
sim/vita_tx_checker.sv
sim/vita_tx_tb.sv
